// File: hw/fetch_align.sv
`timescale 1ns/100ps

module fetch_align (
  input  logic              clk,
  input  logic              rst_n,
  // decode handshake
  input  logic              req_i,
  input  logic              force_nop_i,
  input  logic              boot_i,
  input  logic              stall_id_i,
  output logic              ack_o,
  // pc selector
  input  logic [31:0]       next_pc_i,
  output logic [31:0]       curr_pc_o,
  output logic [31:0]       incr_pc_o,
  // memory port
  output logic              mem_req_o,
  output logic [31:0]       mem_addr_o,
  input  logic              mem_ack_i,
  input  logic [31:0]       mem_rdata_i,
  input  logic [31:0]       mem_last_addr_i,
  // IF/ID
  output fetch_pkg::if_id_t if_id_o,
  output logic              id_valid_o
);

  typedef enum logic [1:0] {
    ST_INVALID,
    ST_VALID,
    ST_FETCH,
    ST_FETCH_NEXT
  } fetch_state_e;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // word address and halfword offset of the current pc
  logic [31:0] fetch_addr_q;
  logic        pc_offset_q;

  // two-word buffer, arr[0] at tag, arr[1] at tag - 4 when prev_ok
  logic [31:0]       data_tag_q;
  logic [1:0][31:0]  data_arr_q;
  logic              buf_valid_q;
  logic              prev_ok_q;

  logic        hit_cur;
  logic        hit_prev;
  logic        ack_match;
  logic        buf_wr;
  logic        nop_int;
  logic        pc_load;
  logic [31:0] lo_word;
  logic [31:0] hi_word;
  logic        hi_ok;
  logic [31:0] instr_int;
  logic [31:0] instr_out;
  logic        is_compressed;

  fetch_pkg::if_id_t if_id_q;
  logic              id_valid_q;

  assign curr_pc_o  = {fetch_addr_q[31:2], pc_offset_q, 1'b0};
  assign mem_addr_o = (state_q == ST_FETCH_NEXT) ? fetch_addr_q + 32'd4 : fetch_addr_q;

  // stale words after a boot carry another address
  assign ack_match = mem_ack_i && (mem_last_addr_i == mem_addr_o);

  assign hit_cur  = buf_valid_q && (fetch_addr_q == data_tag_q);
  assign hit_prev = prev_ok_q && (fetch_addr_q == data_tag_q - 32'd4);

  //////////////////////////////
  // realignment
  //////////////////////////////

  always_comb begin
    hi_ok = 1'b0;
    unique case (state_q)
      ST_FETCH: begin
        lo_word = mem_rdata_i;
        hi_word = mem_rdata_i;
      end
      ST_FETCH_NEXT: begin
        // lower half of the straddling instr is already buffered
        lo_word = data_arr_q[0];
        hi_word = mem_rdata_i;
      end
      default: begin
        if (hit_prev) begin
          lo_word = data_arr_q[1];
          hi_word = data_arr_q[0];
          hi_ok   = 1'b1;
        end else begin
          lo_word = data_arr_q[0];
          hi_word = data_arr_q[0];
        end
      end
    endcase
  end

  assign instr_int     = pc_offset_q ? {hi_word[15:0], lo_word[31:16]} : lo_word;
  assign is_compressed = (instr_int[1:0] != 2'b11);
  assign incr_pc_o     = curr_pc_o + (is_compressed ? 32'd2 : 32'd4);

  // compressed instrs leave with a clean upper half
  always_comb begin
    if (nop_int) begin
      instr_out = fetch_pkg::INSTR_NOP;
    end else if (is_compressed) begin
      instr_out = {16'h0000, instr_int[15:0]};
    end else begin
      instr_out = instr_int;
    end
  end

  //////////////////////////////
  // fetch FSM
  //////////////////////////////

  always_comb begin
    state_d   = state_q;
    ack_o     = 1'b0;
    nop_int   = 1'b0;
    mem_req_o = 1'b0;
    buf_wr    = 1'b0;

    unique case (state_q)
      ST_INVALID: begin
        if (req_i && force_nop_i) begin
          nop_int = 1'b1;
          ack_o   = 1'b1;
        end else if (req_i) begin
          state_d = ST_FETCH;
        end
      end

      ST_VALID: begin
        if (req_i && force_nop_i) begin
          nop_int = 1'b1;
          ack_o   = 1'b1;
        end else if (req_i && (hit_cur || hit_prev)) begin
          // 32-bit at offset 2 needs the following word
          if (pc_offset_q && !is_compressed && !hi_ok) begin
            state_d = ST_FETCH_NEXT;
          end else begin
            ack_o = 1'b1;
          end
        end else if (req_i) begin
          state_d = ST_FETCH;
        end
      end

      ST_FETCH: begin
        mem_req_o = 1'b1;
        if (ack_match) begin
          buf_wr = 1'b1;
          if (pc_offset_q && !is_compressed) begin
            state_d = ST_FETCH_NEXT;
          end else begin
            ack_o   = 1'b1;
            state_d = ST_VALID;
          end
        end
      end

      ST_FETCH_NEXT: begin
        mem_req_o = 1'b1;
        if (ack_match) begin
          buf_wr  = 1'b1;
          ack_o   = 1'b1;
          state_d = ST_VALID;
        end
      end
    endcase

    if (boot_i) begin
      state_d = ST_INVALID;
    end
  end

  // a nop does not move the pc
  assign pc_load = ack_o && !nop_int;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= ST_INVALID;
      fetch_addr_q <= '0;
      pc_offset_q  <= 1'b0;
      buf_valid_q  <= 1'b0;
      prev_ok_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (boot_i || pc_load) begin
        fetch_addr_q <= {next_pc_i[31:2], 2'b00};
        pc_offset_q  <= next_pc_i[1];
      end
      if (boot_i) begin
        buf_valid_q <= 1'b0;
        prev_ok_q   <= 1'b0;
      end else if (buf_wr) begin
        buf_valid_q <= 1'b1;
        // sequential refill keeps the older word usable
        prev_ok_q   <= buf_valid_q && (mem_last_addr_i == data_tag_q + 32'd4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (buf_wr) begin
      data_tag_q    <= mem_last_addr_i;
      data_arr_q[1] <= data_arr_q[0];
      data_arr_q[0] <= mem_rdata_i;
    end
  end

  //////////////////////////////
  // IF/ID registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
    end else if (!stall_id_i) begin
      id_valid_q <= ack_o;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_id_i && ack_o) begin
      if_id_q.instr <= instr_out;
      if_id_q.pc    <= curr_pc_o;
    end
  end

  assign if_id_o    = if_id_q;
  assign id_valid_o = id_valid_q;

endmodule

// File: hw/fetch_pkg.sv
package fetch_pkg;

  //////////////////////////////
  // next-PC selection codes
  //////////////////////////////

  // base source of the next fetch address
  typedef enum logic [2:0] {
    PC_HOLD      = 3'd0,
    PC_INCR      = 3'd1,
    PC_EXCEPTION = 3'd2,
    PC_ERET      = 3'd3,
    PC_BOOT      = 3'd4
  } pc_sel_e;

  // exception vector choice
  typedef enum logic [1:0] {
    EXC_PC_HOLD    = 2'd0,
    EXC_PC_ILLINSN = 2'd1,
    EXC_PC_IRQ     = 2'd2,
    EXC_PC_IRQ_NM  = 2'd3
  } exc_sel_e;

  // control transfer resolved in execute
  typedef enum logic [1:0] {
    JUMP_NONE   = 2'd0,
    JUMP_JAL    = 2'd1,
    JUMP_BRANCH = 2'd2
  } jump_e;

  // vector offsets, appended to boot_addr[31:5]
  localparam logic [4:0] EXC_OFF_RST     = 5'h10;
  localparam logic [4:0] EXC_OFF_ILLINSN = 5'h14;
  localparam logic [4:0] EXC_OFF_IRQ     = 5'h00;
  localparam logic [4:0] EXC_OFF_IRQ_NM  = 5'h0c;

  // addi x0, x0, 0
  localparam logic [6:0]  OPCODE_OPIMM = 7'h13;
  localparam logic [31:0] INSTR_NOP    = {25'b0, OPCODE_OPIMM};

  //////////////////////////////
  // bundles
  //////////////////////////////

  // control from the core, held with the request
  typedef struct packed {
    pc_sel_e     pc_sel;
    exc_sel_e    exc_sel;
    jump_e       jump_kind;
    logic        branch_taken;
    logic [31:0] jump_target;
    logic [31:0] eret_pc;
  } fetch_ctrl_t;

  // IF/ID pipeline register contents
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
  } if_id_t;

endpackage

// File: hw/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [31:0]            boot_addr_i,
  // decode handshake
  input  logic                   req_i,
  input  logic                   force_nop_i,
  // loads next pc, so pair it with pc_sel = PC_BOOT
  input  logic                   boot_i,
  input  logic                   stall_id_i,
  input  fetch_pkg::fetch_ctrl_t ctrl_i,
  output logic                   ack_o,
  output fetch_pkg::if_id_t      if_id_o,
  output logic                   id_valid_o,
  // instruction memory
  output logic                   instr_req_o,
  output logic [31:0]            instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  logic [31:0]            instr_rdata_i
);

  logic [31:0] next_pc;
  logic [31:0] curr_pc;
  logic [31:0] incr_pc;

  // aligner to memory port
  logic        mem_req;
  logic [31:0] mem_addr;
  logic        mem_ack;
  logic [31:0] mem_rdata;
  logic [31:0] mem_last_addr;

  pc_select u_pc_select (
    .ctrl_i      (ctrl_i),
    .boot_addr_i (boot_addr_i),
    .curr_pc_i   (curr_pc),
    .incr_pc_i   (incr_pc),
    .next_pc_o   (next_pc)
  );

  instr_mem_port u_mem_port (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (mem_req),
    .addr_i         (mem_addr),
    .ack_o          (mem_ack),
    .rdata_o        (mem_rdata),
    .last_addr_o    (mem_last_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i)
  );

  fetch_align u_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .force_nop_i     (force_nop_i),
    .boot_i          (boot_i),
    .stall_id_i      (stall_id_i),
    .ack_o           (ack_o),
    .next_pc_i       (next_pc),
    .curr_pc_o       (curr_pc),
    .incr_pc_o       (incr_pc),
    .mem_req_o       (mem_req),
    .mem_addr_o      (mem_addr),
    .mem_ack_i       (mem_ack),
    .mem_rdata_i     (mem_rdata),
    .mem_last_addr_i (mem_last_addr),
    .if_id_o         (if_id_o),
    .id_valid_o      (id_valid_o)
  );

endmodule

// File: hw/instr_mem_port.sv
`timescale 1ns/100ps

module instr_mem_port (
  input  logic        clk,
  input  logic        rst_n,
  // fetch side
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        ack_o,
  output logic [31:0] rdata_o,
  output logic [31:0] last_addr_o,
  // instruction memory
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_GNT,
    ST_WAIT_RVALID
  } port_state_e;

  port_state_e state_q;
  port_state_e state_d;

  // address frozen while the grant is pending
  logic [31:0] addr_q;
  // address of the word in flight or last returned
  logic [31:0] last_addr_q;

  //////////////////////////////
  // request controller
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    instr_req_o  = 1'b0;
    instr_addr_o = addr_i;
    ack_o        = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        // request goes out in the same cycle
        instr_req_o = req_i;
        if (req_i) begin
          state_d = instr_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
        end
      end

      ST_WAIT_GNT: begin
        // keep asking with the captured address, even if req_i drops
        instr_req_o  = 1'b1;
        instr_addr_o = addr_q;
        if (instr_gnt_i) begin
          state_d = ST_WAIT_RVALID;
        end
      end

      ST_WAIT_RVALID: begin
        // single word outstanding, no new request until it returns
        if (instr_rvalid_i) begin
          ack_o   = 1'b1;
          state_d = ST_IDLE;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE) begin
      addr_q <= addr_i;
    end
    // remember what was granted
    if (instr_req_o && instr_gnt_i) begin
      last_addr_q <= instr_addr_o;
    end
  end

  // read data passes straight through with the ack
  assign rdata_o     = instr_rdata_i;
  assign last_addr_o = last_addr_q;

endmodule

// File: hw/pc_select.sv
`timescale 1ns/100ps

module pc_select (
  input  fetch_pkg::fetch_ctrl_t ctrl_i,
  input  logic [31:0]            boot_addr_i,
  // pc of the instruction being served
  input  logic [31:0]            curr_pc_i,
  // curr_pc_i plus the size of that instruction
  input  logic [31:0]            incr_pc_i,
  output logic [31:0]            next_pc_o
);

  logic [31:0] exc_pc;
  logic [31:0] rst_vec;
  logic [31:0] base_pc;

  // reset vector lives in the same 32-byte block as the others
  assign rst_vec = {boot_addr_i[31:5], fetch_pkg::EXC_OFF_RST};

  //////////////////////////////
  // exception vector
  //////////////////////////////

  always_comb begin
    unique case (ctrl_i.exc_sel)
      fetch_pkg::EXC_PC_HOLD:    exc_pc = curr_pc_i;
      fetch_pkg::EXC_PC_ILLINSN: exc_pc = {boot_addr_i[31:5], fetch_pkg::EXC_OFF_ILLINSN};
      fetch_pkg::EXC_PC_IRQ:     exc_pc = {boot_addr_i[31:5], fetch_pkg::EXC_OFF_IRQ};
      fetch_pkg::EXC_PC_IRQ_NM:  exc_pc = {boot_addr_i[31:5], fetch_pkg::EXC_OFF_IRQ_NM};
    endcase
  end

  //////////////////////////////
  // base choice
  //////////////////////////////

  always_comb begin
    case (ctrl_i.pc_sel)
      fetch_pkg::PC_HOLD:      base_pc = curr_pc_i;
      fetch_pkg::PC_INCR:      base_pc = incr_pc_i;
      fetch_pkg::PC_EXCEPTION: base_pc = exc_pc;
      fetch_pkg::PC_ERET:      base_pc = ctrl_i.eret_pc;
      // boot and unused codes
      default:                 base_pc = rst_vec;
    endcase
  end

  // execute-stage transfers win over the base choice
  always_comb begin
    next_pc_o = base_pc;
    if (ctrl_i.jump_kind == fetch_pkg::JUMP_JAL) begin
      next_pc_o = ctrl_i.jump_target;
    end else if (ctrl_i.jump_kind == fetch_pkg::JUMP_BRANCH) begin
      // not taken falls through to the next instruction
      next_pc_o = ctrl_i.branch_taken ? ctrl_i.jump_target : incr_pc_i;
    end
    // boot has the last word
    if (ctrl_i.pc_sel == fetch_pkg::PC_BOOT) begin
      next_pc_o = rst_vec;
    end
  end

endmodule

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module fetch_tb \
  --Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/fetch_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// File: tb.f
hw/fetch_pkg.sv
hw/pc_select.sv
hw/instr_mem_port.sv
hw/fetch_align.sv
hw/fetch_top.sv
test/fetch_chk.sv
test/fetch_mon.sv
test/fetch_tb.sv

// File: test/fetch_cases.txt
# M word_addr data
# R pc_sel exc_sel jump taken target eret nop stall exp_pc exp_instr ; B = boot pulse
M 00000000 00100093
M 00000004 00200113
M 00000008 00300193
M 0000000c 45010505
M 00000010 02130001
M 00000014 45850040
M 00000020 00b00593
M 00000040 00600313
M 00000060 00800413
M 00000064 00900493
M 00000080 00e00713
M 0000008c 00f00793
M 00000090 00c00613
M 00000094 00a00513
M 00000098 00d00693
M 0000009c 01000813
R 1 0 0 0 00000000 00000000 0 0 00000000 00100093
R 1 0 0 0 00000000 00000000 0 0 00000004 00200113
R 1 0 0 0 00000000 00000000 0 0 00000008 00300193
R 1 0 0 0 00000000 00000000 0 0 0000000c 00000505
R 1 0 0 0 00000000 00000000 0 0 0000000e 00004501
R 1 0 0 0 00000000 00000000 0 0 00000010 00000001
R 1 0 0 0 00000000 00000000 0 0 00000012 00400213
R 1 0 1 0 00000040 00000000 0 0 00000016 00004585
R 1 0 2 1 00000060 00000000 0 0 00000040 00600313
R 1 0 2 0 00000010 00000000 0 0 00000060 00800413
R 2 1 0 0 00000000 00000000 0 0 00000064 00900493
R 3 0 0 0 00000000 00000020 0 0 00000094 00a00513
R 2 2 0 0 00000000 00000000 0 0 00000020 00b00593
R 2 3 0 0 00000000 00000000 0 0 00000080 00e00713
R 1 0 0 0 00000000 00000000 0 0 0000008c 00f00793
B
R 1 0 0 0 00000000 00000000 0 0 00000090 00c00613
R 1 0 0 0 00000000 00000000 1 0 00000094 00000013
R 1 0 0 0 00000000 00000000 0 1 00000094 00a00513
R 1 0 0 0 00000000 00000000 0 0 00000098 00d00693
R 1 0 0 0 00000000 00000000 0 0 0000009c 01000813

// File: test/fetch_chk.sv
`timescale 1ns/100ps

module fetch_chk (
  input logic        clk,
  input logic        rst_n,
  input logic        ack_i,
  input logic        instr_req_i,
  input logic [31:0] instr_addr_i,
  input logic        instr_gnt_i,
  input logic        instr_rvalid_i
);

  // a granted word not yet returned
  logic outstanding_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= 1'b0;
    end else if (instr_req_i && instr_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  //////////////////////////////
  // memory protocol
  //////////////////////////////

  req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else $error("memory request dropped or moved before its grant");

  rvalid_granted_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> outstanding_q)
    else $error("rvalid with no outstanding grant");

  ack_in_reset_a: assert property (@(posedge clk) !rst_n |-> !ack_i)
    else $error("ack_o high during reset");

endmodule

// File: test/fetch_mon.sv
`timescale 1ns/100ps

module fetch_mon (
  input logic              clk,
  input logic              rst_n,
  input logic              ack_i,
  input logic              stall_i,
  input logic              id_valid_i,
  input fetch_pkg::if_id_t if_id_i
);

  // filled by the testbench, one entry per unstalled request
  fetch_pkg::if_id_t exp_q[$];
  int mismatch_cnt = 0;
  int other_cnt = 0;

  fetch_pkg::if_id_t exp;
  fetch_pkg::if_id_t prev;
  logic              prev_valid;
  logic              load_seen = 1'b0;
  logic              stall_seen = 1'b0;

  // outputs settle at the rising edge, so look at the falling one
  always @(negedge clk) begin
    if (stall_seen) begin
      // stalled decode keeps the old contents
      if (if_id_i !== prev) begin
        $display("mismatch at %0t: if_id_o expected %h got %h",
                 $time, prev, if_id_i);
        mismatch_cnt = mismatch_cnt + 1;
      end
      if (id_valid_i !== prev_valid) begin
        $display("mismatch at %0t: id_valid_o expected %b got %b",
                 $time, prev_valid, id_valid_i);
        mismatch_cnt = mismatch_cnt + 1;
      end
    end else begin
      // valid follows the ack of the cycle before
      if (id_valid_i !== load_seen) begin
        $display("mismatch at %0t: id_valid_o expected %b got %b",
                 $time, load_seen, id_valid_i);
        mismatch_cnt = mismatch_cnt + 1;
      end
      if (id_valid_i) begin
        if (exp_q.size() == 0) begin
          $display("IF/ID loaded at %0t with nothing expected", $time);
          other_cnt = other_cnt + 1;
        end else begin
          exp = exp_q.pop_front();
          if (if_id_i.pc !== exp.pc) begin
            $display("mismatch at %0t: if_id_o.pc expected %h got %h",
                     $time, exp.pc, if_id_i.pc);
            mismatch_cnt = mismatch_cnt + 1;
          end
          if (if_id_i.instr !== exp.instr) begin
            $display("mismatch at %0t: if_id_o.instr expected %h got %h",
                     $time, exp.instr, if_id_i.instr);
            mismatch_cnt = mismatch_cnt + 1;
          end
        end
      end
    end
    prev       = if_id_i;
    prev_valid = id_valid_i;
    // just before the next rising edge
    #3;
    load_seen  = rst_n && ack_i && !stall_i;
    stall_seen = rst_n && stall_i;
  end

endmodule

// File: test/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

  // one line of the case file
  typedef struct packed {
    logic                   is_boot;
    fetch_pkg::fetch_ctrl_t ctrl;
    logic                   nop;
    logic                   stall;
    logic [31:0]            pc;
    logic [31:0]            instr;
  } req_rec_t;

  logic                   clk;
  logic                   rst_n;
  logic [31:0]            boot_addr_i;
  logic                   req_i;
  logic                   force_nop_i;
  logic                   boot_i;
  logic                   stall_id_i;
  fetch_pkg::fetch_ctrl_t ctrl_i;
  logic                   ack_o;
  fetch_pkg::if_id_t      if_id_o;
  logic                   id_valid_o;
  logic                   instr_req_o;
  logic [31:0]            instr_addr_o;
  logic                   instr_gnt_i;
  logic                   instr_rvalid_i;
  logic [31:0]            instr_rdata_i;

  logic [31:0] mem [logic [31:0]];
  req_rec_t    recs[$];
  int unsigned lcg_state = 25467;
  int          cycle_cnt = 0;
  int          cycle_limit = 50;
  int          other_errs = 0;

  // memory model state
  logic        rv_pending;
  logic [31:0] rv_addr;
  int          rv_wait;
  int          gnt_wait;

  fetch_top UUT (.*);

  fetch_mon u_mon (
    .clk        (clk),
    .rst_n      (rst_n),
    .ack_i      (ack_o),
    .stall_i    (stall_id_i),
    .id_valid_i (id_valid_o),
    .if_id_i    (if_id_o)
  );

  bind fetch_top fetch_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .ack_i          (ack_o),
    .instr_req_i    (instr_req_o),
    .instr_addr_i   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i)
  );

  always #4 clk = ~clk;

  // 0 to 3 cycles of delay
  function automatic int lcg_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[17:16]);
  endfunction

  // unloaded words get a pattern built from the whole address
  function automatic logic [31:0] read_word(logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return addr ^ 32'h5a5a_c3c3;
  endfunction

  // one closing line with all error counts
  task automatic show_counts();
    $display("errors: %0d mismatches, %0d other", u_mon.mismatch_cnt,
             other_errs + u_mon.other_cnt);
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  always @(negedge clk) begin
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    if (!rst_n) begin
      rv_pending = 1'b0;
      gnt_wait   = lcg_delay();
    end else if (rv_pending) begin
      if (rv_wait == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = read_word(rv_addr);
        rv_pending     = 1'b0;
      end else begin
        rv_wait = rv_wait - 1;
      end
    end else if (instr_req_o) begin
      if (gnt_wait == 0) begin
        instr_gnt_i = 1'b1;
        rv_addr     = {instr_addr_o[31:2], 2'b00};
        rv_pending  = 1'b1;
        rv_wait     = lcg_delay();
        gnt_wait    = lcg_delay();
      end else begin
        gnt_wait = gnt_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, fetch stopped answering", cycle_cnt);
      other_errs = other_errs + 1;
      show_counts();
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////
  // case file
  //////////////////////////////

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    string       tag;
    logic [31:0] f [10];
    req_rec_t    r;
    fd = $fopen("test/fetch_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/fetch_cases.txt");
      other_errs = other_errs + 1;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%s", tag);
      if (n == 1 && tag == "M") begin
        n = $sscanf(line, "M %h %h", f[0], f[1]);
        mem[f[0]] = f[1];
      end else if (n == 1 && tag == "B") begin
        r = '0;
        r.is_boot = 1'b1;
        r.ctrl.pc_sel = fetch_pkg::PC_BOOT;
        recs.push_back(r);
      end else if (n == 1 && tag == "R") begin
        n = $sscanf(line, "R %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
        r = '0;
        r.ctrl.pc_sel       = fetch_pkg::pc_sel_e'(f[0][2:0]);
        r.ctrl.exc_sel      = fetch_pkg::exc_sel_e'(f[1][1:0]);
        r.ctrl.jump_kind    = fetch_pkg::jump_e'(f[2][1:0]);
        r.ctrl.branch_taken = f[3][0];
        r.ctrl.jump_target  = f[4];
        r.ctrl.eret_pc      = f[5];
        r.nop               = f[6][0];
        r.stall             = f[7][0];
        r.pc                = f[8];
        r.instr             = f[9];
        recs.push_back(r);
      end
    end
    $fclose(fd);
  endtask

  // starts and ends on a falling edge
  task automatic run_request(req_rec_t r);
    logic acked;
    fetch_pkg::if_id_t e;
    acked       = 1'b0;
    ctrl_i      = r.ctrl;
    force_nop_i = r.nop;
    stall_id_i  = r.stall;
    req_i       = 1'b1;
    // a stalled request never reaches IF/ID
    if (!r.stall) begin
      e.pc    = r.pc;
      e.instr = r.instr;
      u_mon.exp_q.push_back(e);
    end
    while (!acked) begin
      #3;
      if (ack_o) begin
        acked = 1'b1;
      end
      @(negedge clk);
    end
    req_i       = 1'b0;
    force_nop_i = 1'b0;
    stall_id_i  = 1'b0;
  endtask

  task automatic pulse_boot(req_rec_t r);
    ctrl_i = r.ctrl;
    boot_i = 1'b1;
    @(negedge clk);
    boot_i = 1'b0;
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    boot_addr_i    = 32'h0000_0080;
    req_i          = 1'b0;
    force_nop_i    = 1'b0;
    boot_i         = 1'b0;
    stall_id_i     = 1'b0;
    ctrl_i         = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    load_cases();
    cycle_limit = recs.size() * 12 + 50;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    foreach (recs[i]) begin
      if (recs[i].is_boot) begin
        pulse_boot(recs[i]);
      end else begin
        run_request(recs[i]);
      end
    end
    repeat (4) @(negedge clk);
    if (u_mon.exp_q.size() != 0) begin
      $display("%0d expected instructions never reached IF/ID", u_mon.exp_q.size());
      other_errs = other_errs + 1;
    end
    show_counts();
    if (u_mon.mismatch_cnt + u_mon.other_cnt + other_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
